/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_i2s_dma
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* i2s_dma_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_dma_fsm (
    input  wire                     WBs_CLK_i,
    input  wire                     WBs_RST_i,
    input  wire                     i2s_en_i,
    input  wire                     dma_start_i,
    input  wire                     dma_active_i,
    input  wire                     fifo_pop_i,
    input  wire i2s_dma_pkg::dma_cnt_t dma_cnt_i,
    output logic                    dma_req_o,
    output logic                    dma_busy_o,
    output logic                    dma_done_o,
    output logic                    dma_clr_o,
    output logic                    dma_active_sync_o,
    output i2s_dma_pkg::dma_state_e dma_state_o,
    output i2s_dma_pkg::dma_cnt_t   dma_cntr_o
);

    import i2s_dma_pkg::*;

    dma_state_e state_nxt;
    logic       req_nxt;
    logic       busy_nxt;
    logic       done_nxt;
    logic       clr_nxt;
    logic       active_1ff;

    // ------------------------------------------------------------------------
    // Registered outputs and DMA active synchronizer
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            dma_state_o       <= DMA_IDLE;
            dma_req_o         <= 1'b0;
            dma_busy_o        <= 1'b0;
            dma_done_o        <= 1'b0;
            dma_clr_o         <= 1'b0;
            active_1ff        <= 1'b0;
            dma_active_sync_o <= 1'b0;
        end
        else if (!i2s_en_i)
        begin
            // Disabled, back to idle
            dma_state_o       <= DMA_IDLE;
            dma_req_o         <= 1'b0;
            dma_busy_o        <= 1'b0;
            dma_done_o        <= 1'b0;
            dma_clr_o         <= 1'b0;
            active_1ff        <= 1'b0;
            dma_active_sync_o <= 1'b0;
        end
        else
        begin
            dma_state_o       <= state_nxt;
            dma_req_o         <= req_nxt;
            dma_busy_o        <= busy_nxt;
            dma_done_o        <= done_nxt;
            dma_clr_o         <= clr_nxt;
            active_1ff        <= dma_active_i;
            dma_active_sync_o <= active_1ff;
        end
    end

    // Pop counter, held at zero while idle
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            dma_cntr_o <= '0;
        else if (!i2s_en_i || dma_state_o == DMA_IDLE)
            dma_cntr_o <= '0;
        else if (fifo_pop_i)
            dma_cntr_o <= dma_cntr_o + dma_cnt_t'(1);
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb
    begin
        state_nxt = DMA_IDLE;
        req_nxt   = 1'b0;
        busy_nxt  = 1'b0;
        done_nxt  = 1'b0;
        clr_nxt   = 1'b0;
        case (dma_state_o)
            DMA_IDLE:
            begin
                if (dma_start_i)
                begin
                    state_nxt = DMA_START;
                    req_nxt   = 1'b1;
                    busy_nxt  = 1'b1;
                end
            end
            DMA_START:
            begin
                // Start dropped falls through to idle
                if (dma_start_i)
                begin
                    busy_nxt = 1'b1;
                    if (dma_active_sync_o)
                    begin
                        state_nxt = DMA_XFR_PRGSS;
                        clr_nxt   = 1'b1;
                    end
                    else
                    begin
                        state_nxt = DMA_START;
                        req_nxt   = 1'b1;
                    end
                end
            end
            DMA_XFR_PRGSS:
            begin
                busy_nxt = 1'b1;
                if (dma_cntr_o == dma_cnt_i)
                begin
                    state_nxt = DMA_DONE;
                    done_nxt  = 1'b1;
                end
                else
                    state_nxt = DMA_XFR_PRGSS;
            end
            default:
                state_nxt = DMA_IDLE;
        endcase
    end

    a_done_after_xfr: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        dma_done_o |-> $past(dma_state_o) == DMA_XFR_PRGSS);

    a_req_clr_excl: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        !(dma_req_o && dma_clr_o));

endmodule

`default_nettype wire

/* i2s_dma_pkg.sv */
`default_nettype none

package i2s_dma_pkg;

    // Widths fixed by the register map
    typedef logic [15:0] sample_t;
    typedef logic [8:0]  dma_cnt_t;
    typedef logic [4:0]  fifo_lvl_t;
    typedef logic [3:0]  fifo_ptr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [1:0]  wb_addr_t;

    // Receive FIFO entries
    localparam int FIFO_DEPTH = 16;

    // Wishbone word addresses
    localparam wb_addr_t REG_CTRL      = 2'd0;
    localparam wb_addr_t REG_DMA_CNT   = 2'd1;
    localparam wb_addr_t REG_STATUS    = 2'd2;
    localparam wb_addr_t REG_FIFO_DATA = 2'd3;

    // DMA request state machine
    typedef enum logic [1:0] {
        DMA_IDLE      = 2'd0,
        DMA_START     = 2'd1,
        DMA_XFR_PRGSS = 2'd2,
        DMA_DONE      = 2'd3
    } dma_state_e;

endpackage

`default_nettype wire

/* i2s_dma_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_dma_regs (
    input  wire                        WBs_CLK_i,
    input  wire                        WBs_RST_i,
    input  wire i2s_dma_pkg::wb_addr_t wbs_adr_i,
    input  wire i2s_dma_pkg::wb_data_t wbs_dat_i,
    input  wire                        wbs_we_i,
    input  wire                        wbs_stb_i,
    input  wire                        wbs_cyc_i,
    output i2s_dma_pkg::wb_data_t      wbs_dat_o,
    output logic                       wbs_ack_o,
    input  wire i2s_dma_pkg::sample_t  fifo_rd_data_i,
    input  wire i2s_dma_pkg::fifo_lvl_t fifo_level_i,
    input  wire                        fifo_empty_i,
    input  wire                        fifo_ovf_i,
    input  wire                        dma_busy_i,
    input  wire                        dma_done_i,
    input  wire                        dma_clr_i,
    input  wire                        dma_active_sync_i,
    input  wire i2s_dma_pkg::dma_state_e dma_state_i,
    input  wire i2s_dma_pkg::dma_cnt_t dma_cntr_i,
    output logic                       i2s_en_o,
    output logic                       dma_start_o,
    output i2s_dma_pkg::dma_cnt_t      dma_cnt_o,
    output logic                       fifo_pop_o,
    output logic                       irq_o
);

    import i2s_dma_pkg::*;

    logic     wb_req;
    logic     wb_wr;
    logic     wb_rd;
    logic     done_q;
    logic     ovf_q;
    wb_data_t rd_mux;

    // New request, answered with ack on the next cycle
    assign wb_req = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    assign wb_wr  = wb_req & wbs_we_i;
    assign wb_rd  = wb_req & ~wbs_we_i;
    assign irq_o  = done_q;

    always_comb
    begin
        case (wbs_adr_i)
            REG_CTRL:    rd_mux = {30'd0, dma_start_o, i2s_en_o};
            REG_DMA_CNT: rd_mux = {23'd0, dma_cnt_o};
            REG_STATUS:  rd_mux = {7'd0, dma_cntr_i, 3'd0, fifo_level_i, 2'd0,
                                   dma_state_i, dma_active_sync_i, dma_busy_i, ovf_q, done_q};
            // Empty FIFO reads as zero
            default:     rd_mux = fifo_empty_i ? '0 : {16'd0, fifo_rd_data_i};
        endcase
    end

    // ------------------------------------------------------------------------
    // Bus handshake, control registers, pop strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wbs_ack_o   <= 1'b0;
            wbs_dat_o   <= '0;
            fifo_pop_o  <= 1'b0;
            i2s_en_o    <= 1'b0;
            dma_start_o <= 1'b0;
            dma_cnt_o   <= '0;
        end
        else
        begin
            wbs_ack_o  <= wb_req;
            // Pop lands in the ack cycle, after the head was captured
            fifo_pop_o <= wb_rd & (wbs_adr_i == REG_FIFO_DATA) & ~fifo_empty_i;
            if (wb_rd)
                wbs_dat_o <= rd_mux;
            if (wb_wr && wbs_adr_i == REG_CTRL)
            begin
                i2s_en_o    <= wbs_dat_i[0];
                dma_start_o <= wbs_dat_i[1];
            end
            else if (dma_done_i)
                // Start bit self-clears once the transfer completes
                dma_start_o <= 1'b0;
            if (wb_wr && wbs_adr_i == REG_DMA_CNT)
                dma_cnt_o <= wbs_dat_i[8:0];
        end
    end

    // ------------------------------------------------------------------------
    // Sticky done and overflow
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            done_q <= 1'b0;
            ovf_q  <= 1'b0;
        end
        else if (!i2s_en_o || dma_clr_i)
        begin
            done_q <= 1'b0;
            ovf_q  <= 1'b0;
        end
        else
        begin
            // Set wins over write-one-to-clear
            if (dma_done_i)
                done_q <= 1'b1;
            else if (wb_wr && wbs_adr_i == REG_STATUS && wbs_dat_i[0])
                done_q <= 1'b0;
            if (fifo_ovf_i)
                ovf_q <= 1'b1;
        end
    end

    a_pop_on_data_read: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        fifo_pop_o |-> wbs_ack_o && !wbs_we_i && wbs_adr_i == REG_FIFO_DATA
                       && $past(!fifo_empty_i));

endmodule

`default_nettype wire

/* i2s_dma_testdata.txt */
// Word 0: transfer count N; then N lines, each a left and a right 16-bit sample (hex)
// Samples are sent and expected in order, left before right
000a
a5c3 1e0f
8001 7ffe
0000 ffff
3c5a c3a5
1234 edcb
f00d 0ff0
5555 aaaa
7e81 817e
0123 fedc
9b4d 64b2

/* i2s_dma_top.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_dma_top (
    input  wire                        WBs_CLK_i,
    input  wire                        WBs_RST_i,
    input  wire                        i2s_sclk_i,
    input  wire                        i2s_ws_i,
    input  wire                        i2s_sd_i,
    input  wire i2s_dma_pkg::wb_addr_t wbs_adr_i,
    input  wire i2s_dma_pkg::wb_data_t wbs_dat_i,
    input  wire                        wbs_we_i,
    input  wire                        wbs_stb_i,
    input  wire                        wbs_cyc_i,
    output i2s_dma_pkg::wb_data_t      wbs_dat_o,
    output logic                       wbs_ack_o,
    input  wire                        dma_active_i,
    output logic                       dma_req_o,
    output logic                       irq_o
);

    import i2s_dma_pkg::*;

    // Register block controls
    logic       i2s_en;
    logic       dma_start;
    dma_cnt_t   dma_cnt;
    logic       fifo_pop;

    // Receiver to FIFO
    logic       rx_push;
    sample_t    rx_data;

    // FIFO status
    sample_t    rd_data;
    fifo_lvl_t  level;
    logic       empty;
    logic       ovf_pulse;

    // State machine status
    logic       dma_busy;
    logic       dma_done;
    logic       dma_clr;
    logic       dma_active_sync;
    dma_state_e dma_state;
    dma_cnt_t   dma_cntr;

    i2s_rx_deser u_rx_deser (
        .WBs_CLK_i (WBs_CLK_i),
        .WBs_RST_i (WBs_RST_i),
        .i2s_en_i  (i2s_en),
        .i2s_sclk_i(i2s_sclk_i),
        .i2s_ws_i  (i2s_ws_i),
        .i2s_sd_i  (i2s_sd_i),
        .rx_push_o (rx_push),
        .rx_data_o (rx_data)
    );

    // Flushed while disabled
    i2s_rx_fifo u_rx_fifo (
        .WBs_CLK_i  (WBs_CLK_i),
        .WBs_RST_i  (WBs_RST_i),
        .flush_i    (~i2s_en),
        .push_i     (rx_push),
        .push_data_i(rx_data),
        .pop_i      (fifo_pop),
        .rd_data_o  (rd_data),
        .level_o    (level),
        .empty_o    (empty),
        .ovf_o      (ovf_pulse)
    );

    i2s_dma_fsm u_dma_fsm (
        .WBs_CLK_i        (WBs_CLK_i),
        .WBs_RST_i        (WBs_RST_i),
        .i2s_en_i         (i2s_en),
        .dma_start_i      (dma_start),
        .dma_active_i     (dma_active_i),
        .fifo_pop_i       (fifo_pop),
        .dma_cnt_i        (dma_cnt),
        .dma_req_o        (dma_req_o),
        .dma_busy_o       (dma_busy),
        .dma_done_o       (dma_done),
        .dma_clr_o        (dma_clr),
        .dma_active_sync_o(dma_active_sync),
        .dma_state_o      (dma_state),
        .dma_cntr_o       (dma_cntr)
    );

    i2s_dma_regs u_dma_regs (
        .WBs_CLK_i        (WBs_CLK_i),
        .WBs_RST_i        (WBs_RST_i),
        .wbs_adr_i        (wbs_adr_i),
        .wbs_dat_i        (wbs_dat_i),
        .wbs_we_i         (wbs_we_i),
        .wbs_stb_i        (wbs_stb_i),
        .wbs_cyc_i        (wbs_cyc_i),
        .wbs_dat_o        (wbs_dat_o),
        .wbs_ack_o        (wbs_ack_o),
        .fifo_rd_data_i   (rd_data),
        .fifo_level_i     (level),
        .fifo_empty_i     (empty),
        .fifo_ovf_i       (ovf_pulse),
        .dma_busy_i       (dma_busy),
        .dma_done_i       (dma_done),
        .dma_clr_i        (dma_clr),
        .dma_active_sync_i(dma_active_sync),
        .dma_state_i      (dma_state),
        .dma_cntr_i       (dma_cntr),
        .i2s_en_o         (i2s_en),
        .dma_start_o      (dma_start),
        .dma_cnt_o        (dma_cnt),
        .fifo_pop_o       (fifo_pop),
        .irq_o            (irq_o)
    );

endmodule

`default_nettype wire

/* i2s_rx_deser.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_rx_deser (
    input  wire                  WBs_CLK_i,
    input  wire                  WBs_RST_i,
    input  wire                  i2s_en_i,
    input  wire                  i2s_sclk_i,
    input  wire                  i2s_ws_i,
    input  wire                  i2s_sd_i,
    output logic                 rx_push_o,
    output i2s_dma_pkg::sample_t rx_data_o
);

    import i2s_dma_pkg::*;

    // Two-flop synchronizers, bit order {sclk, ws, sd}
    logic [2:0] sync_1ff;
    logic [2:0] sync_2ff;
    logic       sclk_d;
    logic       sclk_rise;

    // Word framing
    logic       ws_prev;
    logic       bit_act;
    logic [3:0] bit_cnt;
    sample_t    shift_q;

    // ------------------------------------------------------------------------
    // Line synchronizers and bit clock edge detect
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            sync_1ff <= 3'b000;
            sync_2ff <= 3'b000;
            sclk_d   <= 1'b0;
        end
        else
        begin
            sync_1ff <= {i2s_sclk_i, i2s_ws_i, i2s_sd_i};
            sync_2ff <= sync_1ff;
            sclk_d   <= sync_2ff[2];
        end
    end

    assign sclk_rise = sync_2ff[2] & ~sclk_d;

    // ------------------------------------------------------------------------
    // Framing, one bit delay after each word select change
    // ------------------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ws_prev   <= 1'b1;
            bit_act   <= 1'b0;
            bit_cnt   <= 4'd0;
            rx_push_o <= 1'b0;
        end
        else if (!i2s_en_i)
        begin
            // Idle high so a low word select arms the first left word
            ws_prev   <= 1'b1;
            bit_act   <= 1'b0;
            bit_cnt   <= 4'd0;
            rx_push_o <= 1'b0;
        end
        else
        begin
            rx_push_o <= 1'b0;
            if (sclk_rise)
            begin
                ws_prev <= sync_2ff[1];
                // Shift edge; the 16th lands on the next word select change
                if (bit_act)
                begin
                    if (bit_cnt == 4'd15)
                    begin
                        bit_act   <= 1'b0;
                        rx_push_o <= 1'b1;
                    end
                    bit_cnt <= bit_cnt + 4'd1;
                end
                // New left or right word, overrides the end of the last one
                if (sync_2ff[1] != ws_prev)
                begin
                    bit_act <= 1'b1;
                    bit_cnt <= 4'd0;
                end
            end
        end
    end

    // Sample shifter, MSB first
    always_ff @(posedge WBs_CLK_i)
    begin
        if (sclk_rise && bit_act)
        begin
            shift_q <= {shift_q[14:0], sync_2ff[0]};
            if (bit_cnt == 4'd15)
                rx_data_o <= {shift_q[14:0], sync_2ff[0]};
        end
    end

    // Words are at least 16 bit clocks apart
    a_push_single: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        rx_push_o |=> !rx_push_o);

endmodule

`default_nettype wire

/* i2s_rx_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_rx_fifo (
    input  wire                    WBs_CLK_i,
    input  wire                    WBs_RST_i,
    input  wire                    flush_i,
    input  wire                    push_i,
    input  wire i2s_dma_pkg::sample_t push_data_i,
    input  wire                    pop_i,
    output i2s_dma_pkg::sample_t   rd_data_o,
    output i2s_dma_pkg::fifo_lvl_t level_o,
    output logic                   empty_o,
    output logic                   ovf_o
);

    import i2s_dma_pkg::*;

    sample_t   mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_lvl_t level_q;
    logic      full;
    logic      do_pop;
    logic      do_push;

    assign full    = (level_q == fifo_lvl_t'(FIFO_DEPTH));
    assign empty_o = (level_q == '0);
    assign level_o = level_q;

    // A pop in the same cycle makes room for a push into a full FIFO
    assign do_pop  = pop_i & ~empty_o & ~flush_i;
    assign do_push = push_i & (~full | do_pop) & ~flush_i;

    // Head entry always visible
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
            ovf_o   <= 1'b0;
        end
        else if (flush_i)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
            ovf_o   <= 1'b0;
        end
        else
        begin
            // Dropped push
            ovf_o <= push_i & ~do_push;
            if (do_push)
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            level_q <= level_q + fifo_lvl_t'(do_push) - fifo_lvl_t'(do_pop);
        end
    end

    always_ff @(posedge WBs_CLK_i)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    a_level_max: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        level_o <= fifo_lvl_t'(FIFO_DEPTH));

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk_o
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial
    begin
        clk_o = 1'b0;
        forever
            #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* tb_i2s_dma.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_i2s_dma;

    import i2s_dma_pkg::*;

    logic     clk;
    logic     rst;
    logic     sclk;
    logic     ws;
    logic     sd;
    wb_addr_t wbs_adr;
    wb_data_t wbs_dat;
    logic     wbs_we;
    logic     wbs_stb;
    logic     wbs_cyc;
    wb_data_t wbs_rdat;
    logic     wbs_ack;
    logic     dma_active;
    logic     dma_req;
    logic     irq;

    // Word 0 holds the pair count and the left and right samples follow
    sample_t     tdata [0:63];
    int          n_pairs;
    logic [31:0] rng;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    tb_clkgen u_clkgen (
        .clk_o(clk)
    );

    i2s_dma_top dut_i (
        .WBs_CLK_i   (clk),
        .WBs_RST_i   (rst),
        .i2s_sclk_i  (sclk),
        .i2s_ws_i    (ws),
        .i2s_sd_i    (sd),
        .wbs_adr_i   (wbs_adr),
        .wbs_dat_i   (wbs_dat),
        .wbs_we_i    (wbs_we),
        .wbs_stb_i   (wbs_stb),
        .wbs_cyc_i   (wbs_cyc),
        .wbs_dat_o   (wbs_rdat),
        .wbs_ack_o   (wbs_ack),
        .dma_active_i(dma_active),
        .dma_req_o   (dma_req),
        .irq_o       (irq)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic stop_with_failure;
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_val(input string what, input wb_data_t got, input wb_data_t exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // Xorshift32 step
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Testdata sample by stream index wrapping over the 2N samples
    function automatic sample_t sample_at(input int idx);
        return tdata[1 + (idx % (2 * n_pairs))];
    endfunction

    // Run limit
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            $display("Timeout, the run exceeded %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    // ------------------------------------------------------------------------
    // I2S bit driver
    // ------------------------------------------------------------------------
    // One bit slot with the lines changing while sclk is low and sampled on the rise
    task automatic i2s_slot(input logic ws_v, input logic sd_v);
        int half;
        rng  = next_random(rng);
        half = 4 + int'(rng % 32'd4);
        @(negedge clk);
        sclk = 1'b0;
        ws   = ws_v;
        sd   = sd_v;
        repeat (half) @(negedge clk);
        sclk = 1'b1;
        repeat (half - 1) @(negedge clk);
    endtask

    // Even word count sent left first with ws flipping on the LSB of all but the last word
    task automatic send_samples(input int first, input int count);
        sample_t word;
        logic    ws_v;
        // Arm slot drops ws from its idle high
        i2s_slot(1'b0, 1'b0);
        for (int k = 0; k < count; k++)
        begin
            word = sample_at(first + k);
            ws_v = k[0];
            for (int b = 15; b >= 0; b--)
                i2s_slot((b == 0 && k != count - 1) ? ~ws_v : ws_v, word[b]);
        end
        // Let the last push reach the FIFO
        repeat (6) @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------------
    task automatic wait_ack;
        int n;
        n = 0;
        @(negedge clk);
        while (!wbs_ack && n < 16)
        begin
            @(negedge clk);
            n++;
        end
        assert (wbs_ack)
        else
        begin
            $display("No Wishbone acknowledge for address %0d at %0t ns", wbs_adr, $time);
            stop_with_failure();
        end
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        @(negedge clk);
        wbs_adr = addr;
        wbs_dat = data;
        wbs_we  = 1'b1;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        wait_ack();
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        @(negedge clk);
        wbs_adr = addr;
        wbs_we  = 1'b0;
        wbs_stb = 1'b1;
        wbs_cyc = 1'b1;
        wait_ack();
        data    = wbs_rdat;
        // Address and direction held until the next access
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
    endtask

    // Field checks on STATUS where a negative value skips the field
    task automatic check_status(input string tag, input int done, input int ovf,
                                input int busy, input int state, input int level,
                                input int cntr);
        wb_data_t st;
        wb_read(REG_STATUS, st);
        if (done >= 0)
            check_val({tag, " done"}, wb_data_t'(st[0]), wb_data_t'(done));
        if (ovf >= 0)
            check_val({tag, " overflow"}, wb_data_t'(st[1]), wb_data_t'(ovf));
        if (busy >= 0)
            check_val({tag, " busy"}, wb_data_t'(st[2]), wb_data_t'(busy));
        if (state >= 0)
            check_val({tag, " state"}, wb_data_t'(st[5:4]), wb_data_t'(state));
        if (level >= 0)
            check_val({tag, " level"}, wb_data_t'(st[12:8]), wb_data_t'(level));
        if (cntr >= 0)
            check_val({tag, " counter"}, wb_data_t'(st[24:16]), wb_data_t'(cntr));
    endtask

    // Poll dma_req_o or irq_o for a level
    task automatic wait_line(input bit use_irq, input logic val, input string what);
        int   n;
        logic cur;
        n   = 0;
        cur = use_irq ? irq : dma_req;
        while (cur !== val && n < 200)
        begin
            @(negedge clk);
            n++;
            cur = use_irq ? irq : dma_req;
        end
        assert (cur === val)
        else
        begin
            $display("Timed out at %0t ns waiting for %s", $time, what);
            stop_with_failure();
        end
    endtask

    task automatic wait_state(input dma_state_e exp);
        wb_data_t st;
        int       n;
        n = 0;
        wb_read(REG_STATUS, st);
        while (st[5:4] != exp && n < 20)
        begin
            wb_read(REG_STATUS, st);
            n++;
        end
        assert (st[5:4] == exp)
        else
        begin
            $display("Timed out at %0t ns waiting for DMA state %0d", $time, exp);
            stop_with_failure();
        end
    endtask

    task automatic read_and_compare(input string what, input wb_data_t exp);
        wb_data_t rd;
        wb_read(REG_FIFO_DATA, rd);
        check_val(what, rd, exp);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int pops;
        rst        = 1'b1;
        sclk       = 1'b0;
        ws         = 1'b1;
        sd         = 1'b0;
        wbs_adr    = '0;
        wbs_dat    = '0;
        wbs_we     = 1'b0;
        wbs_stb    = 1'b0;
        wbs_cyc    = 1'b0;
        dma_active = 1'b0;
        rng        = 32'h5c91_b9a8;
        $readmemh("i2s_dma_testdata.txt", tdata);
        n_pairs = int'(tdata[0]);
        if (n_pairs < 10 || n_pairs > 31)
        begin
            $display("Testdata must hold 10 to 31 sample pairs, it holds %0d", n_pairs);
            stop_with_failure();
        end
        // 8 + 2N + 20 + 2 samples, 32 bits, 16 cycles each
        cycle_limit = (30 + 2 * n_pairs) * 32 * 16 + 2000;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state
        check_val("dma_req_o after reset", wb_data_t'(dma_req), 32'd0);
        check_val("irq_o after reset", wb_data_t'(irq), 32'd0);
        check_status("Reset STATUS", 0, -1, 0, DMA_IDLE, 0, -1);

        // Sample order without DMA
        wb_write(REG_CTRL, 32'h1);
        send_samples(0, 8);
        check_status("After 8 samples", -1, -1, -1, -1, 8, -1);
        for (int i = 0; i < 8; i++)
            read_and_compare("FIFO sample", wb_data_t'(sample_at(i)));
        check_status("After 8 reads", -1, -1, -1, -1, 0, -1);

        // DMA sequence of N pops
        wb_write(REG_DMA_CNT, wb_data_t'(n_pairs));
        wb_write(REG_CTRL, 32'h3);
        wait_line(1'b0, 1'b1, "dma_req_o to rise");
        check_val("irq_o after start", wb_data_t'(irq), 32'd0);
        dma_active = 1'b1;
        wait_line(1'b0, 1'b0, "dma_req_o to fall");
        pops = 0;
        for (int f = 0; f < n_pairs; f++)
        begin
            send_samples(2 * f, 2);
            read_and_compare("DMA left sample", wb_data_t'(sample_at(2 * f)));
            read_and_compare("DMA right sample", wb_data_t'(sample_at(2 * f + 1)));
            pops += 2;
            if (pops < n_pairs)
                check_val("irq_o before N pops", wb_data_t'(irq), 32'd0);
            else
                wait_line(1'b1, 1'b1, "irq_o after N pops");
        end
        check_status("After DMA", 1, 0, 0, DMA_IDLE, 0, 0);
        dma_active = 1'b0;

        // Overflow, then a read of the empty FIFO
        send_samples(0, 20);
        check_status("After 20 samples", -1, 1, -1, -1, FIFO_DEPTH, -1);
        for (int i = 0; i < FIFO_DEPTH; i++)
            read_and_compare("Kept sample", wb_data_t'(sample_at(i)));
        read_and_compare("Empty FIFO read", 32'd0);
        check_status("After empty read", -1, -1, -1, -1, 0, -1);

        // Restart with active already high clears the sticky bits
        dma_active = 1'b1;
        wb_write(REG_CTRL, 32'h3);
        wait_state(DMA_XFR_PRGSS);
        check_status("After restart", 0, 0, 1, DMA_XFR_PRGSS, -1, -1);
        check_val("irq_o after restart", wb_data_t'(irq), 32'd0);
        check_val("dma_req_o after restart", wb_data_t'(dma_req), 32'd0);

        // Disable with a request pending and samples queued
        wb_write(REG_CTRL, 32'h0);
        dma_active = 1'b0;
        wb_write(REG_CTRL, 32'h3);
        wait_line(1'b0, 1'b1, "dma_req_o to rise again");
        send_samples(0, 2);
        check_status("Pending request", -1, -1, 1, DMA_START, 2, -1);
        wb_write(REG_CTRL, 32'h0);
        // The registered request drops one clock after the enable register
        @(negedge clk);
        check_val("dma_req_o after disable", wb_data_t'(dma_req), 32'd0);
        check_val("irq_o after disable", wb_data_t'(irq), 32'd0);
        check_status("After disable", -1, -1, 0, DMA_IDLE, 0, -1);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
i2s_dma_pkg.sv
i2s_rx_deser.sv
i2s_rx_fifo.sv
i2s_dma_fsm.sv
i2s_dma_regs.sv
i2s_dma_top.sv
tb_clkgen.sv
tb_i2s_dma.sv
